// File: hw/cam_cfg.svh
`ifndef CAM_CFG_SVH
`define CAM_CFG_SVH

// pixel and measurement widths.
`define CAM_PIXEL_BITS      10
`define CAM_SIZE_BITS       16

// peripheral bus widths.
`define CAM_ADDR_BITS       40
`define CAM_DATA_BITS       64

// byte offsets of the registers on the 64-bit bus.
`define CAM_REG_ID          'h00
`define CAM_REG_CTRL        'h08
`define CAM_REG_FRAMES      'h10
`define CAM_REG_WIDTH       'h18
`define CAM_REG_HEIGHT      'h20

// the identification word reads as "CAMCAP" plus a revision.
`define CAM_ID_VALUE        64'h4341_4d43_4150_0001

`endif

// File: hw/cam_pkg.sv
`default_nettype none

`include "cam_cfg.svh"

package cam_pkg;

    typedef logic   [`CAM_PIXEL_BITS-1:0]   pixel_t;
    typedef logic   [`CAM_SIZE_BITS-1:0]    size_t;

    typedef logic   [`CAM_ADDR_BITS-1:0]    axi_addr_t;
    typedef logic   [`CAM_DATA_BITS-1:0]    axi_data_t;
    typedef logic   [1:0]                   axi_resp_t;

endpackage

`default_nettype wire

// File: hw/video_if.sv
`timescale 1ns/10ps
`default_nettype none

interface video_if
        (
            input   logic   aclk
        );
    import cam_pkg::*;

    pixel_t     tdata;
    logic       tuser;      // first pixel of a frame.
    logic       tlast;      // last pixel of a line.
    logic       tvalid;
    logic       tready;

    modport src (
        input   aclk,
        output  tdata,
        output  tuser,
        output  tlast,
        output  tvalid,
        input   tready
    );

    modport dst (
        input   aclk,
        input   tdata,
        input   tuser,
        input   tlast,
        input   tvalid,
        output  tready
    );

endinterface

`default_nettype wire

// File: hw/axi4l_reg_slave.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_cfg.svh"

module axi4l_reg_slave
        (
            input   logic                   aclk            ,
            input   logic                   reset           ,

            input   cam_pkg::axi_addr_t     awaddr          ,
            input   logic   [2:0]           awprot          ,
            input   logic                   awvalid         ,
            output  logic                   awready         ,
            input   cam_pkg::axi_data_t     wdata           ,
            input   logic   [7:0]           wstrb           ,
            input   logic                   wvalid          ,
            output  logic                   wready          ,
            output  cam_pkg::axi_resp_t     bresp           ,
            output  logic                   bvalid          ,
            input   logic                   bready          ,
            input   cam_pkg::axi_addr_t     araddr          ,
            input   logic   [2:0]           arprot          ,
            input   logic                   arvalid         ,
            output  logic                   arready         ,
            output  cam_pkg::axi_data_t     rdata           ,
            output  cam_pkg::axi_resp_t     rresp           ,
            output  logic                   rvalid          ,
            input   logic                   rready          ,

            output  logic                   enable          ,
            output  logic                   clear           ,
            input   cam_pkg::size_t         frame_count     ,
            input   cam_pkg::size_t         line_width      ,
            input   cam_pkg::size_t         frame_height
        );
    import cam_pkg::*;

    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_DECERR = 2'd3;

    logic       write_fire;
    logic       read_fire;
    logic       write_mapped;
    logic       write_ctrl;
    axi_data_t  read_value;
    axi_resp_t  read_status;

    assign write_fire = awready && awvalid && wvalid;
    assign read_fire  = arready && arvalid;
    assign write_ctrl = (awaddr == axi_addr_t'(`CAM_REG_CTRL));

    always_comb begin
        write_mapped = 1'b0;
        case (awaddr)
            axi_addr_t'(`CAM_REG_ID),
            axi_addr_t'(`CAM_REG_CTRL),
            axi_addr_t'(`CAM_REG_FRAMES),
            axi_addr_t'(`CAM_REG_WIDTH),
            axi_addr_t'(`CAM_REG_HEIGHT): write_mapped = 1'b1;
            default: write_mapped = 1'b0;
        endcase
    end

    // the write channel keeps one transaction outstanding at a time.
    always_ff @(posedge aclk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            if (write_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (write_fire) begin
            bresp <= write_mapped ? RESP_OKAY : RESP_DECERR;
        end
    end

    // the clear bit clears itself while enable is a plain level.
    always_ff @(posedge aclk) begin
        if (reset) begin
            enable <= 1'b0;
            clear  <= 1'b0;
        end else begin
            clear <= 1'b0;
            if (write_fire && write_ctrl && wstrb[0]) begin
                enable <= wdata[0];
                clear  <= wdata[1];
            end
        end
    end

    always_comb begin
        read_status = RESP_OKAY;
        case (araddr)
            axi_addr_t'(`CAM_REG_ID):     read_value = `CAM_ID_VALUE;
            axi_addr_t'(`CAM_REG_CTRL):   read_value = axi_data_t'(enable);
            axi_addr_t'(`CAM_REG_FRAMES): read_value = axi_data_t'(frame_count);
            axi_addr_t'(`CAM_REG_WIDTH):  read_value = axi_data_t'(line_width);
            axi_addr_t'(`CAM_REG_HEIGHT): read_value = axi_data_t'(frame_height);
            default: begin
                read_value  = '0;
                read_status = RESP_DECERR;
            end
        endcase
    end

    // read data is captured when the address is accepted.
    always_ff @(posedge aclk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (read_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (read_fire) begin
            rdata <= read_value;
            rresp <= read_status;
        end
    end

endmodule

`default_nettype wire

// File: hw/video_frame_gate.sv
`timescale 1ns/10ps
`default_nettype none

module video_frame_gate
        (
            input   logic       aclk        ,
            input   logic       reset       ,
            input   logic       enable      ,

            video_if.dst        s           ,
            video_if.src        m
        );

    typedef enum logic {
        DROPPING,
        PASSING
    } gate_state_t;

    gate_state_t    state;
    logic           frame_start;
    logic           pass;

    // a frame start decides by enable, any other beat follows the state.
    always_comb begin
        frame_start = s.tvalid && s.tuser;
        if (frame_start) begin
            pass = enable;
        end else begin
            pass = (state == PASSING);
        end
    end

    assign m.tdata  = s.tdata;
    assign m.tuser  = s.tuser;
    assign m.tlast  = s.tlast;
    assign m.tvalid = s.tvalid && pass;
    assign s.tready = pass ? m.tready : 1'b1;   // dropped beats are swallowed.

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= DROPPING;
        end else if (frame_start && s.tready) begin
            state <= pass ? PASSING : DROPPING;
        end
    end

endmodule

`default_nettype wire

// File: hw/video_frame_meter.sv
`timescale 1ns/10ps
`default_nettype none

module video_frame_meter
        (
            input   logic               aclk            ,
            input   logic               reset           ,
            input   logic               clear           ,

            video_if.dst                mon             ,

            output  cam_pkg::size_t     frame_count     ,
            output  cam_pkg::size_t     line_width      ,
            output  cam_pkg::size_t     frame_height
        );
    import cam_pkg::*;

    logic       beat;
    size_t      pixel_next;
    size_t      line_base;
    size_t      pixel_cnt;
    size_t      line_cnt;
    logic       frame_seen;

    assign beat = mon.tvalid && mon.tready;

    // a frame start always opens a new line and a new frame.
    assign pixel_next = (mon.tuser ? size_t'(0) : pixel_cnt) + size_t'(1);
    assign line_base  = mon.tuser ? size_t'(0) : line_cnt;

    always_ff @(posedge aclk) begin
        if (reset) begin
            pixel_cnt  <= '0;
            line_cnt   <= '0;
            frame_seen <= 1'b0;
        end else if (beat) begin
            pixel_cnt <= mon.tlast ? size_t'(0) : pixel_next;
            line_cnt  <= line_base + size_t'(mon.tlast);
            if (mon.tuser) begin
                frame_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (reset || clear) begin
            frame_count  <= '0;
            line_width   <= '0;
            frame_height <= '0;
        end else if (beat) begin
            if (mon.tlast) begin
                line_width <= pixel_next;
            end
            if (mon.tuser) begin
                frame_count <= frame_count + size_t'(1);
                if (frame_seen) begin
                    frame_height <= line_cnt;   // lines of the frame just ended.
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/cam_capture_top.sv
`timescale 1ns/10ps
`default_nettype none

module cam_capture_top
        (
            input   logic                   aclk                    ,
            input   logic                   reset                   ,

            input   cam_pkg::axi_addr_t     s_axi4l_peri_awaddr     ,
            input   logic   [2:0]           s_axi4l_peri_awprot     ,
            input   logic                   s_axi4l_peri_awvalid    ,
            output  logic                   s_axi4l_peri_awready    ,
            input   cam_pkg::axi_data_t     s_axi4l_peri_wdata      ,
            input   logic   [7:0]           s_axi4l_peri_wstrb      ,
            input   logic                   s_axi4l_peri_wvalid     ,
            output  logic                   s_axi4l_peri_wready     ,
            output  cam_pkg::axi_resp_t     s_axi4l_peri_bresp      ,
            output  logic                   s_axi4l_peri_bvalid     ,
            input   logic                   s_axi4l_peri_bready     ,
            input   cam_pkg::axi_addr_t     s_axi4l_peri_araddr     ,
            input   logic   [2:0]           s_axi4l_peri_arprot     ,
            input   logic                   s_axi4l_peri_arvalid    ,
            output  logic                   s_axi4l_peri_arready    ,
            output  cam_pkg::axi_data_t     s_axi4l_peri_rdata      ,
            output  cam_pkg::axi_resp_t     s_axi4l_peri_rresp      ,
            output  logic                   s_axi4l_peri_rvalid     ,
            input   logic                   s_axi4l_peri_rready     ,

            input   cam_pkg::pixel_t        s_axis_tdata            ,
            input   logic                   s_axis_tuser            ,
            input   logic                   s_axis_tlast            ,
            input   logic                   s_axis_tvalid           ,
            output  logic                   s_axis_tready           ,

            output  cam_pkg::pixel_t        m_axis_tdata            ,
            output  logic                   m_axis_tuser            ,
            output  logic                   m_axis_tlast            ,
            output  logic                   m_axis_tvalid           ,
            input   logic                   m_axis_tready
        );
    import cam_pkg::*;

    logic       enable;
    logic       clear;
    size_t      frame_count;
    size_t      line_width;
    size_t      frame_height;

    video_if in_stream (.aclk(aclk));
    video_if out_stream (.aclk(aclk));

    assign in_stream.tdata  = s_axis_tdata;
    assign in_stream.tuser  = s_axis_tuser;
    assign in_stream.tlast  = s_axis_tlast;
    assign in_stream.tvalid = s_axis_tvalid;
    assign s_axis_tready    = in_stream.tready;

    assign m_axis_tdata      = out_stream.tdata;
    assign m_axis_tuser      = out_stream.tuser;
    assign m_axis_tlast      = out_stream.tlast;
    assign m_axis_tvalid     = out_stream.tvalid;
    assign out_stream.tready = m_axis_tready;

    axi4l_reg_slave
        u_reg_slave
            (
                .aclk           (aclk                   ),
                .reset          (reset                  ),
                .awaddr         (s_axi4l_peri_awaddr    ),
                .awprot         (s_axi4l_peri_awprot    ),
                .awvalid        (s_axi4l_peri_awvalid   ),
                .awready        (s_axi4l_peri_awready   ),
                .wdata          (s_axi4l_peri_wdata     ),
                .wstrb          (s_axi4l_peri_wstrb     ),
                .wvalid         (s_axi4l_peri_wvalid    ),
                .wready         (s_axi4l_peri_wready    ),
                .bresp          (s_axi4l_peri_bresp     ),
                .bvalid         (s_axi4l_peri_bvalid    ),
                .bready         (s_axi4l_peri_bready    ),
                .araddr         (s_axi4l_peri_araddr    ),
                .arprot         (s_axi4l_peri_arprot    ),
                .arvalid        (s_axi4l_peri_arvalid   ),
                .arready        (s_axi4l_peri_arready   ),
                .rdata          (s_axi4l_peri_rdata     ),
                .rresp          (s_axi4l_peri_rresp     ),
                .rvalid         (s_axi4l_peri_rvalid    ),
                .rready         (s_axi4l_peri_rready    ),
                .enable         (enable                 ),
                .clear          (clear                  ),
                .frame_count    (frame_count            ),
                .line_width     (line_width             ),
                .frame_height   (frame_height           )
            );

    video_frame_gate
        u_frame_gate
            (
                .aclk           (aclk                   ),
                .reset          (reset                  ),
                .enable         (enable                 ),
                .s              (in_stream.dst          ),
                .m              (out_stream.src         )
            );

    // the meter only watches the gated stream.
    video_frame_meter
        u_frame_meter
            (
                .aclk           (aclk                   ),
                .reset          (reset                  ),
                .clear          (clear                  ),
                .mon            (out_stream.dst         ),
                .frame_count    (frame_count            ),
                .line_width     (line_width             ),
                .frame_height   (frame_height           )
            );

endmodule

`default_nettype wire

// File: bench/tb_cam_capture.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_cfg.svh"

module tb_cam_capture;
    import cam_pkg::*;

    localparam int BUS_TIMEOUT   = 50;
    localparam int BEAT_TIMEOUT  = 400;
    localparam int DRAIN_TIMEOUT = 400;
    localparam int ROW_TIMEOUT   = 4000;

    logic           aclk;
    logic           reset;
    axi_addr_t      s_axi4l_peri_awaddr;
    logic   [2:0]   s_axi4l_peri_awprot;
    logic           s_axi4l_peri_awvalid;
    logic           s_axi4l_peri_awready;
    axi_data_t      s_axi4l_peri_wdata;
    logic   [7:0]   s_axi4l_peri_wstrb;
    logic           s_axi4l_peri_wvalid;
    logic           s_axi4l_peri_wready;
    axi_resp_t      s_axi4l_peri_bresp;
    logic           s_axi4l_peri_bvalid;
    logic           s_axi4l_peri_bready;
    axi_addr_t      s_axi4l_peri_araddr;
    logic   [2:0]   s_axi4l_peri_arprot;
    logic           s_axi4l_peri_arvalid;
    logic           s_axi4l_peri_arready;
    axi_data_t      s_axi4l_peri_rdata;
    axi_resp_t      s_axi4l_peri_rresp;
    logic           s_axi4l_peri_rvalid;
    logic           s_axi4l_peri_rready;
    pixel_t         s_axis_tdata;
    logic           s_axis_tuser;
    logic           s_axis_tlast;
    logic           s_axis_tvalid;
    logic           s_axis_tready;
    pixel_t         m_axis_tdata;
    logic           m_axis_tuser;
    logic           m_axis_tlast;
    logic           m_axis_tvalid;
    logic           m_axis_tready;

    logic   [11:0]  expect_q[$];    // {tuser, tlast, tdata} of every beat that must pass.
    int             seen_count;
    int             monitor_errors;
    int             check_errors;
    logic           timed_out;
    logic           ctrl_enable;    // enable level as last written over the bus.
    int             rows_done;
    logic   [31:0]  bp_percent;
    logic   [31:0]  rng_state;

    cam_capture_top UUT (
        .aclk                   (aclk),
        .reset                  (reset),
        .s_axi4l_peri_awaddr    (s_axi4l_peri_awaddr),
        .s_axi4l_peri_awprot    (s_axi4l_peri_awprot),
        .s_axi4l_peri_awvalid   (s_axi4l_peri_awvalid),
        .s_axi4l_peri_awready   (s_axi4l_peri_awready),
        .s_axi4l_peri_wdata     (s_axi4l_peri_wdata),
        .s_axi4l_peri_wstrb     (s_axi4l_peri_wstrb),
        .s_axi4l_peri_wvalid    (s_axi4l_peri_wvalid),
        .s_axi4l_peri_wready    (s_axi4l_peri_wready),
        .s_axi4l_peri_bresp     (s_axi4l_peri_bresp),
        .s_axi4l_peri_bvalid    (s_axi4l_peri_bvalid),
        .s_axi4l_peri_bready    (s_axi4l_peri_bready),
        .s_axi4l_peri_araddr    (s_axi4l_peri_araddr),
        .s_axi4l_peri_arprot    (s_axi4l_peri_arprot),
        .s_axi4l_peri_arvalid   (s_axi4l_peri_arvalid),
        .s_axi4l_peri_arready   (s_axi4l_peri_arready),
        .s_axi4l_peri_rdata     (s_axi4l_peri_rdata),
        .s_axi4l_peri_rresp     (s_axi4l_peri_rresp),
        .s_axi4l_peri_rvalid    (s_axi4l_peri_rvalid),
        .s_axi4l_peri_rready    (s_axi4l_peri_rready),
        .s_axis_tdata           (s_axis_tdata),
        .s_axis_tuser           (s_axis_tuser),
        .s_axis_tlast           (s_axis_tlast),
        .s_axis_tvalid          (s_axis_tvalid),
        .s_axis_tready          (s_axis_tready),
        .m_axis_tdata           (m_axis_tdata),
        .m_axis_tuser           (m_axis_tuser),
        .m_axis_tlast           (m_axis_tlast),
        .m_axis_tvalid          (m_axis_tvalid),
        .m_axis_tready          (m_axis_tready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin : backpressure
        rng_state     = 32'h2ee3_1ef1;
        m_axis_tready = 1'b1;
        forever begin
            @(negedge aclk);
            rng_state     = xorshift32(rng_state);
            m_axis_tready = (rng_state % 32'd100) >= bp_percent;
        end
    end

    // every output transfer is matched against the next expected beat.
    initial begin : output_monitor
        logic [11:0] expected;
        seen_count     = 0;
        monitor_errors = 0;
        forever begin
            @(posedge aclk);
            if (m_axis_tvalid && seen_count >= expect_q.size()) begin
                $display("error at %0t: m_axis_tvalid is high but no passed beat is pending",
                         $time);
                monitor_errors++;
            end else if (m_axis_tvalid && m_axis_tready) begin
                expected = expect_q[seen_count];
                if ({m_axis_tuser, m_axis_tlast, m_axis_tdata} != expected) begin
                    $display("MISMATCH at %0t: m_axis {tuser,tlast,tdata} got %h expected %h",
                             $time, {m_axis_tuser, m_axis_tlast, m_axis_tdata}, expected);
                    monitor_errors++;
                end
                seen_count++;
            end
        end
    end

    task automatic bus_write(input axi_addr_t addr, input axi_data_t data,
                             output axi_resp_t resp);
        int waited;
        resp = 2'd0;
        @(negedge aclk);
        s_axi4l_peri_awaddr  = addr;
        s_axi4l_peri_awvalid = 1'b1;
        s_axi4l_peri_wdata   = data;
        s_axi4l_peri_wstrb   = 8'hff;
        s_axi4l_peri_wvalid  = 1'b1;
        waited = 0;
        @(posedge aclk);
        while (!(s_axi4l_peri_awready && s_axi4l_peri_wready) && waited < BUS_TIMEOUT) begin
            waited++;
            @(posedge aclk);
        end
        if (!(s_axi4l_peri_awready && s_axi4l_peri_wready)) begin
            $display("timeout at %0t: write address and data were never accepted", $time);
            timed_out = 1'b1;
        end
        @(negedge aclk);
        s_axi4l_peri_awvalid = 1'b0;
        s_axi4l_peri_wvalid  = 1'b0;
        s_axi4l_peri_bready  = 1'b1;
        waited = 0;
        @(posedge aclk);
        while (!s_axi4l_peri_bvalid && waited < BUS_TIMEOUT && !timed_out) begin
            waited++;
            @(posedge aclk);
        end
        if (!s_axi4l_peri_bvalid && !timed_out) begin
            $display("timeout at %0t: no write response arrived", $time);
            timed_out = 1'b1;
        end
        resp = s_axi4l_peri_bresp;
        @(negedge aclk);
        s_axi4l_peri_bready = 1'b0;
    endtask

    task automatic bus_read(input axi_addr_t addr, output axi_data_t data,
                            output axi_resp_t resp);
        int waited;
        @(negedge aclk);
        s_axi4l_peri_araddr  = addr;
        s_axi4l_peri_arvalid = 1'b1;
        waited = 0;
        @(posedge aclk);
        while (!s_axi4l_peri_arready && waited < BUS_TIMEOUT) begin
            waited++;
            @(posedge aclk);
        end
        if (!s_axi4l_peri_arready) begin
            $display("timeout at %0t: read address was never accepted", $time);
            timed_out = 1'b1;
        end
        @(negedge aclk);
        s_axi4l_peri_arvalid = 1'b0;
        s_axi4l_peri_rready  = 1'b1;
        waited = 0;
        @(posedge aclk);
        while (!s_axi4l_peri_rvalid && waited < BUS_TIMEOUT && !timed_out) begin
            waited++;
            @(posedge aclk);
        end
        if (!s_axi4l_peri_rvalid && !timed_out) begin
            $display("timeout at %0t: no read data arrived", $time);
            timed_out = 1'b1;
        end
        data = s_axi4l_peri_rdata;
        resp = s_axi4l_peri_rresp;
        @(negedge aclk);
        s_axi4l_peri_rready = 1'b0;
    endtask

    // the gate decides at the frame start, so the enable level then decides the frame.
    task automatic send_frame(input int width, input int height);
        logic   passes;
        logic   first;
        logic   last;
        pixel_t data;
        int     row;
        int     col;
        int     waited;
        passes = ctrl_enable;
        row    = 0;
        while (row < height && !timed_out) begin
            col = 0;
            while (col < width && !timed_out) begin
                first = (row == 0) && (col == 0);
                last  = (col == width - 1);
                data  = pixel_t'((row * 16 + col) % 1024);
                @(negedge aclk);
                if (passes) begin
                    expect_q.push_back({first, last, data});
                end
                s_axis_tdata  = data;
                s_axis_tuser  = first;
                s_axis_tlast  = last;
                s_axis_tvalid = 1'b1;
                waited = 0;
                @(posedge aclk);
                while (!s_axis_tready && waited < BEAT_TIMEOUT) begin
                    waited++;
                    @(posedge aclk);
                end
                if (!s_axis_tready) begin
                    $display("timeout at %0t: s_axis_tready stayed low", $time);
                    timed_out = 1'b1;
                end else if (!passes && waited > 0) begin
                    $display("error at %0t: s_axis_tready went low while frames are dropped",
                             $time);
                    check_errors++;
                end
                col++;
            end
            rows_done++;
            row++;
        end
        @(negedge aclk);
        s_axis_tvalid = 1'b0;
        s_axis_tuser  = 1'b0;
        s_axis_tlast  = 1'b0;
        waited = 0;
        while (seen_count < expect_q.size() && waited < DRAIN_TIMEOUT && !timed_out) begin
            waited++;
            @(posedge aclk);
        end
        if (seen_count < expect_q.size() && !timed_out) begin
            $display("timeout at %0t: %0d passed beats never left m_axis", $time,
                     expect_q.size() - seen_count);
            timed_out = 1'b1;
        end
    endtask

    initial begin : trace_runner
        int             fd;
        int             fields;
        int             need;
        int             test_num;
        int             failed_tests;
        int             errors_before;
        int             width;
        int             height;
        int             line_at;
        int             waited;
        string          line;
        string          desc;
        logic   [7:0]   cmd;
        logic   [63:0]  a;
        logic   [63:0]  b;
        logic   [63:0]  c;
        axi_data_t      data;
        axi_resp_t      resp;

        reset                = 1'b1;
        s_axi4l_peri_awaddr  = '0;
        s_axi4l_peri_awprot  = 3'd0;
        s_axi4l_peri_awvalid = 1'b0;
        s_axi4l_peri_wdata   = '0;
        s_axi4l_peri_wstrb   = 8'h00;
        s_axi4l_peri_wvalid  = 1'b0;
        s_axi4l_peri_bready  = 1'b0;
        s_axi4l_peri_araddr  = '0;
        s_axi4l_peri_arprot  = 3'd0;
        s_axi4l_peri_arvalid = 1'b0;
        s_axi4l_peri_rready  = 1'b0;
        s_axis_tdata         = '0;
        s_axis_tuser         = 1'b0;
        s_axis_tlast         = 1'b0;
        s_axis_tvalid        = 1'b0;
        bp_percent           = 32'd0;
        check_errors         = 0;
        timed_out            = 1'b0;
        ctrl_enable          = 1'b0;
        rows_done            = 0;
        test_num             = 0;
        failed_tests         = 0;

        repeat (5) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;

        fd = $fopen("bench/cam_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file bench/cam_trace.txt");
            check_errors++;
        end
        while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                errors_before = check_errors + monitor_errors;
                fields = $sscanf(line, "%c", cmd);
                need   = 1;
                test_num++;
                case (cmd)
                    "W": begin
                        fields = $sscanf(line, "%c %h %h %h", cmd, a, b, c);
                        need   = 4;
                        desc   = $sformatf("write 0x%0h <= 0x%0h", a, b);
                        bus_write(axi_addr_t'(a), b, resp);
                        if (axi_addr_t'(a) == axi_addr_t'(`CAM_REG_CTRL)) begin
                            ctrl_enable = b[0];
                        end
                        if (!timed_out && resp != c[1:0]) begin
                            $display("MISMATCH at %0t: s_axi4l_peri_bresp got %0d expected %0d",
                                     $time, resp, c[1:0]);
                            check_errors++;
                        end
                    end
                    "R": begin
                        fields = $sscanf(line, "%c %h %h %h", cmd, a, b, c);
                        need   = 4;
                        desc   = $sformatf("read 0x%0h", a);
                        bus_read(axi_addr_t'(a), data, resp);
                        if (!timed_out && data != b) begin
                            $display("MISMATCH at %0t: s_axi4l_peri_rdata got 0x%h expected 0x%h",
                                     $time, data, b);
                            check_errors++;
                        end
                        if (!timed_out && resp != c[1:0]) begin
                            $display("MISMATCH at %0t: s_axi4l_peri_rresp got %0d expected %0d",
                                     $time, resp, c[1:0]);
                            check_errors++;
                        end
                    end
                    "F": begin
                        fields    = $sscanf(line, "%c %d %d", cmd, width, height);
                        need      = 3;
                        desc      = $sformatf("frame %0dx%0d", width, height);
                        rows_done = 0;
                        send_frame(width, height);
                    end
                    "C": begin
                        fields = $sscanf(line, "%c %d %d %d %h", cmd, width, height, line_at, b);
                        need   = 5;
                        desc   = $sformatf("frame %0dx%0d, ctrl 0x%0h at line %0d",
                                           width, height, b, line_at);
                        rows_done = 0;
                        fork
                            send_frame(width, height);
                            begin
                                waited = 0;
                                while (rows_done < line_at && waited < ROW_TIMEOUT) begin
                                    waited++;
                                    @(posedge aclk);
                                end
                                if (rows_done < line_at && !timed_out) begin
                                    $display("timeout at %0t: line %0d of the frame never came",
                                             $time, line_at);
                                    timed_out = 1'b1;
                                end
                                bus_write(axi_addr_t'(`CAM_REG_CTRL), b, resp);
                                ctrl_enable = b[0];
                            end
                        join
                        if (!timed_out && resp != 2'd0) begin
                            $display("MISMATCH at %0t: s_axi4l_peri_bresp got %0d expected 0",
                                     $time, resp);
                            check_errors++;
                        end
                    end
                    "B": begin
                        fields = $sscanf(line, "%c %d", cmd, bp_percent);
                        need   = 2;
                        desc   = $sformatf("back-pressure %0d%%", bp_percent);
                    end
                    default: begin
                        desc = "unknown trace command";
                        $display("the trace holds a line with no known command: %s", line);
                        check_errors++;
                    end
                endcase
                if (fields != need) begin
                    $display("the trace line for %s holds %0d fields instead of %0d",
                             desc, fields, need);
                    check_errors++;
                end
                if (timed_out || check_errors + monitor_errors != errors_before) begin
                    failed_tests++;
                    $display("test %0d: %s failed", test_num, desc);
                end else begin
                    $display("test %0d: %s ok", test_num, desc);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests: %0d, failed: %0d, errors: %0d", test_num, failed_tests,
                 check_errors + monitor_errors);
        if (!timed_out && test_num > 0 && failed_tests == 0
                && check_errors + monitor_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/cam_pkg.sv
hw/video_if.sv
hw/axi4l_reg_slave.sv
hw/video_frame_gate.sv
hw/video_frame_meter.sv
hw/cam_capture_top.sv
bench/tb_cam_capture.sv

// File: Makefile
# Verilator build for the camera capture testbench.

TOP = tb_cam_capture

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --timescale 1ns/10ps \
		--top-module $(TOP) -f files.f -o sim_cam

run: compile
	@out="$$(./obj_dir/sim_cam)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// File: bench/cam_trace.txt
# W offset value resp | R offset data resp | all hex.
# F width height | C width height line ctrl(hex) | B percent | decimal unless marked.
R 00 43414d4341500001 0
R 08 0 0
R 10 0 0
R 18 0 0
R 20 0 0
R 28 0 3
W 00 ffff 0
R 00 43414d4341500001 0
W 40 1 3
F 20 4
R 10 0 0
R 18 0 0
W 08 1 0
R 08 1 0
B 30
F 8 3
F 24 6
F 16 4
R 10 3 0
R 18 10 0
R 20 6 0
C 12 5 2 0
F 10 3
R 08 0 0
R 10 4 0
R 18 c 0
R 20 4 0
W 08 2 0
R 10 0 0
R 18 0 0
R 20 0 0
R 08 0 0
